// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_uart_report
FILELIST   := list.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: design/char_serializer.sv
// Sends one loaded field over the UART port, a character at a time.
// Per character: hold de until busy rises, drop de, then wait for
// busy to fall. A single done strobe follows the last character.
// load is only accepted while idle.

module char_serializer
    import uart_report_pkg::*;
(
    input  logic         CLK,
    input  logic         RST_N,
    input  logic         load,
    input  field_load_t  field,
    input  logic         uart_tx_busy,
    output uart_tx_req_t tx,
    output logic         done
);

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_SEND,
        SER_WAIT
    } ser_state_t;

    ser_state_t     state;
    field_chars_t   shift_buf;
    field_len_t     remaining;
    logic           busy_q;
    logic           busy_rise;
    logic           next_char;

    assign busy_rise = uart_tx_busy & ~busy_q;

    // Busy gone and more characters left
    assign next_char = (state == SER_WAIT) && !uart_tx_busy && (remaining != '0);

    // ----------------------------------------------------------
    // Handshake FSM
    // ----------------------------------------------------------

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state     <= SER_IDLE;
            remaining <= '0;
            busy_q    <= 1'b0;
            tx        <= '0;
            done      <= 1'b0;
        end else begin
            busy_q <= uart_tx_busy;
            done   <= 1'b0;
            case (state)
                SER_IDLE: begin
                    if (load) begin
                        state     <= SER_SEND;
                        remaining <= field.len - 3'd1;
                        tx.de     <= 1'b1;
                        tx.data   <= field.chars[MAX_FIELD_CHARS-1];
                    end
                end
                SER_SEND: begin
                    // Byte taken by the transmitter
                    if (busy_rise) begin
                        tx.de <= 1'b0;
                        state <= SER_WAIT;
                    end
                end
                SER_WAIT: begin
                    if (!uart_tx_busy) begin
                        if (remaining == '0) begin
                            state <= SER_IDLE;
                            done  <= 1'b1;
                        end else begin
                            state     <= SER_SEND;
                            remaining <= remaining - 3'd1;
                            tx.de     <= 1'b1;
                            tx.data   <= shift_buf[MAX_FIELD_CHARS-1];
                        end
                    end
                end
                default: begin
                    state <= SER_IDLE;
                    tx.de <= 1'b0;
                end
            endcase
        end
    end

    // Remaining characters, next one always in the top byte
    always_ff @(posedge CLK) begin
        if (state == SER_IDLE && load) begin
            shift_buf <= field.chars << $bits(char_t);
        end else if (next_char) begin
            shift_buf <= shift_buf << $bits(char_t);
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------

    // Sequencer must wait for done before the next field
    a_load_when_idle : assert property (
        @(posedge CLK) disable iff (!RST_N)
        load |-> state == SER_IDLE
    );

    a_data_stable : assert property (
        @(posedge CLK) disable iff (!RST_N)
        tx.de && $past(tx.de) |-> tx.data == $past(tx.data)
    );

endmodule

// File: design/eye_meas_pkg.sv
// Types for the measurement side of the eye-tracker reporter.
// Holds the sum and divider result widths and the input bundle the
// host drives into the reporter top level.

package eye_meas_pkg;

    // ----------------------------------------------------------
    // Sums and divider results
    // ----------------------------------------------------------

    // Pixel count
    typedef logic [19:0] sum_s_t;

    // Weighted coordinate sum, also used for the fixed-point centroid
    typedef logic [27:0] sum_xy_t;

    typedef logic [19:0] frac_t;
    typedef logic [27:0] quot_t;

    // Centroid = quotient[11:0] followed by fraction[19:4]
    localparam int QUOT_KEEP_BITS = 12;
    localparam int FRAC_DROP_BITS = 4;

    // ----------------------------------------------------------
    // Input bundle
    // ----------------------------------------------------------

    typedef struct packed {
        sum_s_t  sum_s;
        sum_xy_t sum_sx;
        sum_xy_t sum_sy;
        quot_t   quot_sx;
        quot_t   quot_sy;
        frac_t   frac_sx;
        frac_t   frac_sy;
    } eye_sums_t;

endpackage

// File: design/hex_ascii_conv.sv
// Converts an unsigned payload to upper-case hex ASCII, one character
// per nibble, registered. The most significant nibble lands in the top
// character. Set data_t to the payload type.

module hex_ascii_conv #(
    parameter type data_t = logic [27:0]
) (
    input  logic                            CLK,
    input  logic                            RST_N,
    input  data_t                           value,
    output logic [($bits(data_t)+3)/4-1:0][7:0] chars
);

    localparam int DIGITS = ($bits(data_t) + 3) / 4;

    logic [DIGITS*4-1:0]        padded;
    logic [3:0]                 nib;
    logic [DIGITS-1:0][7:0]     chars_next;

    always_comb begin
        padded = '0;
        padded[$bits(data_t)-1:0] = value;
        nib = '0;
        for (int i = 0; i < DIGITS; i++) begin
            nib = padded[i*4 +: 4];
            // 'A' is 0x41, so 0x37 + 10
            if (nib < 4'd10) begin
                chars_next[i] = 8'h30 + {4'h0, nib};
            end else begin
                chars_next[i] = 8'h37 + {4'h0, nib};
            end
        end
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            chars <= '0;
        end else begin
            chars <= chars_next;
        end
    end

endmodule

// File: design/report_sequencer.sv
// Line-format sequencer of the reporter.
// Detects the trigger edge, latches out_sel, then hands the count,
// X, Y and line feed fields to the serializer one after another.
// busy covers the whole line.

module report_sequencer
    import uart_report_pkg::*;
(
    input  logic         CLK,
    input  logic         RST_N,
    input  logic         trig,
    input  logic         out_sel,
    input  field_chars_t s_chars,
    input  field_chars_t sx_chars,
    input  field_chars_t sy_chars,
    input  field_chars_t qx_chars,
    input  field_chars_t qy_chars,
    input  logic         done,
    output logic         load,
    output field_load_t  field,
    output logic         busy
);

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_COUNT,
        SEQ_X,
        SEQ_Y,
        SEQ_LF
    } seq_state_t;

    seq_state_t     state;
    seq_state_t     state_next;
    logic           trig_q;
    logic           trig_qq;
    logic           trig_rise;
    logic           sel_q;
    logic           issue;
    field_load_t    field_next;

    // ----------------------------------------------------------
    // Trigger edge
    // ----------------------------------------------------------

    // Extra stage gives the hex converters their cycle
    assign trig_rise = trig_q & ~trig_qq;

    // ----------------------------------------------------------
    // Line FSM
    // ----------------------------------------------------------

    always_comb begin
        state_next = state;
        issue      = 1'b0;
        field_next = field;
        case (state)
            SEQ_IDLE: begin
                if (trig_rise) begin
                    state_next       = SEQ_COUNT;
                    issue            = 1'b1;
                    field_next.chars = s_chars;
                    field_next.len   = field_len_t'(S_CHARS);
                end
            end
            SEQ_COUNT: begin
                if (done) begin
                    state_next       = SEQ_X;
                    issue            = 1'b1;
                    field_next.chars = sel_q ? qx_chars : sx_chars;
                    field_next.len   = field_len_t'(XY_CHARS);
                end
            end
            SEQ_X: begin
                if (done) begin
                    state_next       = SEQ_Y;
                    issue            = 1'b1;
                    field_next.chars = sel_q ? qy_chars : sy_chars;
                    field_next.len   = field_len_t'(XY_CHARS);
                end
            end
            SEQ_Y: begin
                if (done) begin
                    state_next       = SEQ_LF;
                    issue            = 1'b1;
                    field_next.chars = '0;
                    field_next.chars[MAX_FIELD_CHARS-1] = LINE_FEED;
                    field_next.len   = 3'd1;
                end
            end
            SEQ_LF: begin
                if (done) begin
                    state_next = SEQ_IDLE;
                end
            end
            default: begin
                state_next = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            trig_q  <= 1'b0;
            trig_qq <= 1'b0;
            state   <= SEQ_IDLE;
            sel_q   <= 1'b0;
            load    <= 1'b0;
            busy    <= 1'b0;
        end else begin
            trig_q  <= trig;
            trig_qq <= trig_q;
            state   <= state_next;
            load    <= issue;
            busy    <= (state_next != SEQ_IDLE);
            // Held for the whole line
            if (state == SEQ_IDLE && trig_rise) begin
                sel_q <= out_sel;
            end
        end
    end

    always_ff @(posedge CLK) begin
        field <= field_next;
    end

    // Serializer only finishes fields of a running line
    a_done_in_line : assert property (
        @(posedge CLK) disable iff (!RST_N)
        done |-> busy
    );

endmodule

// File: design/uart_report_pkg.sv
// Types for the text side of the reporter.
// Characters, the field buffer handed from sequencer to serializer,
// the field lengths of one report line and the UART request bundle.

package uart_report_pkg;

    // ----------------------------------------------------------
    // Characters and fields
    // ----------------------------------------------------------

    typedef logic [7:0] char_t;

    localparam int MAX_FIELD_CHARS = 7;

    // Top byte is sent first
    typedef char_t [MAX_FIELD_CHARS-1:0] field_chars_t;

    // Number of characters in a field, 1 to 7
    typedef logic [2:0] field_len_t;

    typedef struct packed {
        field_chars_t chars;
        field_len_t   len;
    } field_load_t;

    // Line layout
    localparam int    S_CHARS   = 5;
    localparam int    XY_CHARS  = 7;
    localparam char_t LINE_FEED = 8'h0A;

    // ----------------------------------------------------------
    // UART transmit port
    // ----------------------------------------------------------

    // de is held until the transmitter raises busy
    typedef struct packed {
        logic  de;
        char_t data;
    } uart_tx_req_t;

endpackage

// File: design/uart_report_top.sv
// Top level of the eye-tracker result reporter.
// On each trig edge one hex text line goes out over the UART port:
// S, then raw sums or centroids as picked by out_sel, then a line feed.

module uart_report_top
    import eye_meas_pkg::*;
    import uart_report_pkg::*;
(
    input  logic         CLK,
    input  logic         RST_N,
    input  logic         trig,
    input  logic         out_sel,
    input  eye_sums_t    sums,
    input  logic         uart_tx_busy,
    output logic         busy,
    output uart_tx_req_t tx
);

    sum_xy_t                    qx_val;
    sum_xy_t                    qy_val;
    logic [S_CHARS-1:0][7:0]    s_hex;
    field_chars_t               s_chars;
    field_chars_t               sx_chars;
    field_chars_t               sy_chars;
    field_chars_t               qx_chars;
    field_chars_t               qy_chars;
    logic                       load;
    field_load_t                field;
    logic                       done;

    // Fixed-point centroid slices
    assign qx_val = {sums.quot_sx[QUOT_KEEP_BITS-1:0],
                     sums.frac_sx[$bits(frac_t)-1:FRAC_DROP_BITS]};
    assign qy_val = {sums.quot_sy[QUOT_KEEP_BITS-1:0],
                     sums.frac_sy[$bits(frac_t)-1:FRAC_DROP_BITS]};

    // Count field sits in the top characters
    assign s_chars = {s_hex, {(MAX_FIELD_CHARS-S_CHARS)*8{1'b0}}};

    // ----------------------------------------------------------
    // Hex converters
    // ----------------------------------------------------------

    hex_ascii_conv #(.data_t(sum_s_t)) u_conv_s (
        .CLK(CLK), .RST_N(RST_N), .value(sums.sum_s), .chars(s_hex)
    );

    hex_ascii_conv #(.data_t(sum_xy_t)) u_conv_sx (
        .CLK(CLK), .RST_N(RST_N), .value(sums.sum_sx), .chars(sx_chars)
    );

    hex_ascii_conv #(.data_t(sum_xy_t)) u_conv_sy (
        .CLK(CLK), .RST_N(RST_N), .value(sums.sum_sy), .chars(sy_chars)
    );

    hex_ascii_conv #(.data_t(sum_xy_t)) u_conv_qx (
        .CLK(CLK), .RST_N(RST_N), .value(qx_val), .chars(qx_chars)
    );

    hex_ascii_conv #(.data_t(sum_xy_t)) u_conv_qy (
        .CLK(CLK), .RST_N(RST_N), .value(qy_val), .chars(qy_chars)
    );

    // ----------------------------------------------------------
    // Line control and UART side
    // ----------------------------------------------------------

    report_sequencer u_seq (
        .CLK      (CLK),
        .RST_N    (RST_N),
        .trig     (trig),
        .out_sel  (out_sel),
        .s_chars  (s_chars),
        .sx_chars (sx_chars),
        .sy_chars (sy_chars),
        .qx_chars (qx_chars),
        .qy_chars (qy_chars),
        .done     (done),
        .load     (load),
        .field    (field),
        .busy     (busy)
    );

    char_serializer u_ser (
        .CLK          (CLK),
        .RST_N        (RST_N),
        .load         (load),
        .field        (field),
        .uart_tx_busy (uart_tx_busy),
        .tx           (tx),
        .done         (done)
    );

endmodule

// File: dv/tb_uart_report.sv
// Testbench for the eye-tracker result reporter.
// Random sums and out_sel per line, a trig pulse, then the received
// bytes are compared with a line built from the hex format rules.
// Handshake rules on the UART port are watched every cycle.

module tb_uart_report
    import eye_meas_pkg::*;
    import uart_report_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned SEED       = 32'hf4cf_decc;
    localparam int          NUM_LINES  = 24;
    localparam int          LINE_BYTES = 20;
    localparam int          WAIT_LIMIT = 2000;

    logic         CLK;
    logic         RST_N;
    logic         trig;
    logic         out_sel;
    eye_sums_t    sums;
    logic         uart_tx_busy;
    logic         busy;
    uart_tx_req_t tx;

    char_t exp_bytes[$];
    int    de_pulses   = 0;
    int    total_bytes = 0;
    int    lines_sent  = 0;
    logic  de_prev     = 1'b0;
    logic  busy_prev   = 1'b0;
    char_t data_prev   = '0;

    uart_report_top u_dut (
        .CLK          (CLK),
        .RST_N        (RST_N),
        .trig         (trig),
        .out_sel      (out_sel),
        .sums         (sums),
        .uart_tx_busy (uart_tx_busy),
        .busy         (busy),
        .tx           (tx)
    );

    uart_tx_responder u_resp (
        .CLK          (CLK),
        .RST_N        (RST_N),
        .tx           (tx),
        .uart_tx_busy (uart_tx_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // ----------------------------------------------------------
    // Error handling
    // ----------------------------------------------------------

    task automatic abort_run(input string what);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", what);
    endtask

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        abort_run(msg);
    endtask

    // ----------------------------------------------------------
    // Line model
    // ----------------------------------------------------------

    function automatic char_t hex_digit(input logic [3:0] nib);
        string digits;
        digits = "0123456789ABCDEF";
        return char_t'(digits[nib]);
    endfunction

    // Most significant digit first
    function automatic void push_hex(input logic [27:0] value, input int ndig);
        for (int i = ndig - 1; i >= 0; i--) begin
            exp_bytes.push_back(hex_digit(value[i*4 +: 4]));
        end
    endfunction

    function automatic void build_expected();
        logic [27:0] x_val;
        logic [27:0] y_val;
        exp_bytes.delete();
        if (out_sel) begin
            x_val = {sums.quot_sx[11:0], sums.frac_sx[19:4]};
            y_val = {sums.quot_sy[11:0], sums.frac_sy[19:4]};
        end else begin
            x_val = sums.sum_sx;
            y_val = sums.sum_sy;
        end
        push_hex({8'h00, sums.sum_s}, 5);
        push_hex(x_val, 7);
        push_hex(y_val, 7);
        exp_bytes.push_back(8'h0A);
    endfunction

    // ----------------------------------------------------------
    // Stimulus and waits
    // ----------------------------------------------------------

    task automatic draw_inputs();
        @(posedge CLK);
        sums.sum_s   <= 20'($urandom);
        sums.sum_sx  <= 28'($urandom);
        sums.sum_sy  <= 28'($urandom);
        sums.quot_sx <= 28'($urandom);
        sums.quot_sy <= 28'($urandom);
        sums.frac_sx <= 20'($urandom);
        sums.frac_sy <= 20'($urandom);
        out_sel      <= 1'($urandom);
    endtask

    task automatic wait_line_busy(input logic level);
        int cycles;
        cycles = 0;
        while (busy !== level) begin
            @(posedge CLK);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run($sformatf("Timed out waiting for busy to become %0b", level));
            end
        end
    endtask

    // UART busy high means the first byte was accepted
    task automatic wait_first_accept();
        int cycles;
        cycles = 0;
        while (uart_tx_busy !== 1'b1) begin
            @(posedge CLK);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("Timed out waiting for the UART to accept a byte");
            end
        end
    endtask

    task automatic check_line();
        char_t got;
        int    nrx;
        nrx = u_resp.rx_bytes.size();
        assert (nrx == LINE_BYTES) else
            report_mismatch($sformatf("line has %0d bytes, expected %0d",
                                      nrx, LINE_BYTES));
        for (int i = 0; i < LINE_BYTES; i++) begin
            got = u_resp.rx_bytes.pop_front();
            assert (got == exp_bytes[i]) else
                report_mismatch($sformatf("line %0d byte %0d is 0x%02h, expected 0x%02h",
                                          lines_sent, i, got, exp_bytes[i]));
        end
        total_bytes += nrx;
        assert (de_pulses == total_bytes) else
            report_mismatch($sformatf("%0d de pulses for %0d bytes", de_pulses, total_bytes));
    endtask

    // ----------------------------------------------------------
    // Handshake monitor
    // ----------------------------------------------------------

    always @(posedge CLK) begin
        if (RST_N) begin
            if (tx.de && !de_prev) begin
                de_pulses++;
                assert (!busy_prev) else
                    report_mismatch("tx.de rose while uart_tx_busy was high");
            end
            if (tx.de && de_prev) begin
                assert (tx.data == data_prev) else
                    report_mismatch("tx.data changed while tx.de was high");
            end
        end
        de_prev   = tx.de;
        busy_prev = uart_tx_busy;
        data_prev = tx.data;
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------

    initial begin
        int unsigned pulse_len;
        void'($urandom(SEED));
        RST_N   = 1'b0;
        trig    = 1'b0;
        out_sel = 1'b0;
        sums    = '0;
        repeat (3) @(posedge CLK);
        RST_N <= 1'b1;

        // Quiet after reset
        repeat (6) begin
            @(posedge CLK);
            assert (!busy && !tx.de) else
                report_mismatch("busy or tx.de high before any trigger");
        end

        for (int line = 0; line < NUM_LINES; line++) begin
            draw_inputs();
            pulse_len = $urandom_range(3, 1);
            @(posedge CLK);
            trig <= 1'b1;
            build_expected();
            repeat (pulse_len) @(posedge CLK);
            trig <= 1'b0;
            wait_line_busy(1'b1);
            // Some lines get a second trig that must be ignored
            if ($urandom_range(1, 0) == 1) begin
                wait_first_accept();
                @(posedge CLK);
                trig <= 1'b1;
                @(posedge CLK);
                trig <= 1'b0;
            end
            wait_line_busy(1'b0);
            check_line();
            lines_sent++;
            repeat ($urandom_range(5, 1)) @(posedge CLK);
        end

        // No extra line may follow
        repeat (30) @(posedge CLK);
        assert (!busy && u_resp.rx_bytes.size() == 0) else
            report_mismatch("extra bytes after the last line");
        assert (de_pulses == LINE_BYTES * lines_sent) else
            report_mismatch($sformatf("%0d bytes for %0d triggers", de_pulses, lines_sent));

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: dv/uart_tx_responder.sv
// UART transmitter model for the reporter testbench.
// Answers each de with a busy pulse of random delay and length, and
// keeps every accepted byte in rx_bytes, oldest first.

module uart_tx_responder
    import uart_report_pkg::*;
(
    input  logic         CLK,
    input  logic         RST_N,
    input  uart_tx_req_t tx,
    output logic         uart_tx_busy
);

    timeunit 1ns;
    timeprecision 1ps;

    char_t       rx_bytes[$];
    int unsigned rise_delay;
    int unsigned hold_cycles;

    initial begin
        uart_tx_busy = 1'b0;
        forever begin
            @(posedge CLK);
            if (RST_N && tx.de && !uart_tx_busy) begin
                // Byte taken on the first cycle de is seen
                rx_bytes.push_back(tx.data);
                rise_delay  = $urandom_range(4, 1);
                hold_cycles = $urandom_range(10, 2);
                repeat (rise_delay - 1) @(posedge CLK);
                uart_tx_busy <= 1'b1;
                repeat (hold_cycles) @(posedge CLK);
                uart_tx_busy <= 1'b0;
            end
        end
    end

endmodule

// File: list.f
design/eye_meas_pkg.sv
design/uart_report_pkg.sv
design/hex_ascii_conv.sv
design/char_serializer.sv
design/report_sequencer.sv
design/uart_report_top.sv
dv/uart_tx_responder.sv
dv/tb_uart_report.sv
